// ==== src/wisc_defines.svh ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// WISC core sizing macros
// Widths, memory depths and the PC reset value
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef WISC_DEFINES_SVH
`define WISC_DEFINES_SVH

`define WORD_W 16     // Data and instruction width

// Register file size, R7 holds the JAL link
`define REG_CNT 8

`define IMEM_DEPTH 256  // Words
`define DMEM_DEPTH 256  // Words

// First fetch address after start
`define PC_RESET 0

`endif

// ==== src/wisc_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// WISC core types
// Word and field types, opcodes, ALU functions, fetch FSM states
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "wisc_defines.svh"

package wisc_pkg;

   typedef logic [`WORD_W-1:0] word_t;
   typedef logic [$clog2(`REG_CNT)-1:0] reg_sel_t;
   typedef logic [4:0] opcode_t;   // instr[15:11]
   typedef logic [1:0] alu_op_t;

   localparam opcode_t OP_HALT  = 5'b00000;
   localparam opcode_t OP_NOP   = 5'b00001;
   localparam opcode_t OP_ADDI  = 5'b01000;
   localparam opcode_t OP_SUBI  = 5'b01001;
   localparam opcode_t OP_XORI  = 5'b01010;
   localparam opcode_t OP_ANDNI = 5'b01011;
   localparam opcode_t OP_RRR   = 5'b11011;  // Function in instr[1:0]
   localparam opcode_t OP_LBI   = 5'b11000;
   localparam opcode_t OP_ST    = 5'b10000;
   localparam opcode_t OP_LD    = 5'b10001;
   localparam opcode_t OP_BEQZ  = 5'b01100;
   localparam opcode_t OP_BNEZ  = 5'b01101;
   localparam opcode_t OP_J     = 5'b00100;
   localparam opcode_t OP_JAL   = 5'b00110;

   // Same order as the register-register function bits
   localparam alu_op_t ALU_ADD  = 2'b00;
   localparam alu_op_t ALU_SUB  = 2'b01;  // Operand b minus a
   localparam alu_op_t ALU_XOR  = 2'b10;
   localparam alu_op_t ALU_ANDN = 2'b11;

   localparam word_t NOP_INSTR = {OP_NOP, {(`WORD_W-5){1'b0}}};

   typedef enum logic [1:0] {FETCH_IDLE, FETCH_RUN, FETCH_HALTED} fetch_state_t;

endpackage

// ==== src/fetch.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Fetch stage
// Instruction memory with load port, PC and run FSM
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none
`include "wisc_defines.svh"

module fetch (
   input  logic            clk,
   input  logic            arst_n,
   input  logic            load_en,
   input  wisc_pkg::word_t load_addr,
   input  wisc_pkg::word_t load_data,
   input  logic            start,
   input  logic            stall,
   input  logic            redirect,
   input  wisc_pkg::word_t target,
   input  logic            halt_wb,
   output wisc_pkg::word_t instr_f,
   output wisc_pkg::word_t pc_next_f,
   output logic            halted
);

   localparam int AW = $clog2(`IMEM_DEPTH);

   wisc_pkg::word_t        imem [`IMEM_DEPTH];
   wisc_pkg::word_t        pc;
   wisc_pkg::fetch_state_t state;

   // Word addressed, byte address bit 0 ignored
   always_ff @(posedge clk) begin
      if (load_en) begin
         imem[load_addr[AW:1]] <= load_data;
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state <= wisc_pkg::FETCH_IDLE;
         pc    <= wisc_pkg::word_t'(`PC_RESET);
      end else begin
         case (state)
            wisc_pkg::FETCH_IDLE: begin
               if (start) begin
                  state <= wisc_pkg::FETCH_RUN;
                  pc    <= wisc_pkg::word_t'(`PC_RESET);
               end
            end
            wisc_pkg::FETCH_RUN: begin
               if (halt_wb) begin
                  state <= wisc_pkg::FETCH_HALTED;
               end else if (redirect) begin
                  pc <= target;           // Redirect beats stall
               end else if (!stall) begin
                  pc <= pc_next_f;
               end
            end
            default: state <= wisc_pkg::FETCH_HALTED;  // Stays until reset
         endcase
      end
   end

   assign instr_f   = (state == wisc_pkg::FETCH_RUN) ? imem[pc[AW:1]] : wisc_pkg::NOP_INSTR;
   assign pc_next_f = pc + wisc_pkg::word_t'(2);
   assign halted    = (state == wisc_pkg::FETCH_HALTED);

endmodule

`default_nettype wire

// ==== src/decode.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Decode stage
// Control decode, register file and immediate extension
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none
`include "wisc_defines.svh"

module decode (
   input  logic               clk,
   input  logic               arst_n,
   input  wisc_pkg::word_t    instr_d,
   input  logic               wr_en,
   input  wisc_pkg::reg_sel_t wr_sel,
   input  wisc_pkg::word_t    wr_data,
   output wisc_pkg::word_t    rd1_data,
   output wisc_pkg::word_t    rd2_data,
   output wisc_pkg::word_t    imm,
   output wisc_pkg::reg_sel_t dest,
   output logic               reg_write,
   output logic               mem_read,
   output logic               mem_write,
   output logic               alu_src,
   output logic               link,
   output logic               halt,
   output logic               err
);

   wisc_pkg::word_t    regs [`REG_CNT];
   wisc_pkg::opcode_t  opcode;
   wisc_pkg::reg_sel_t src1;
   wisc_pkg::reg_sel_t src2;
   wisc_pkg::word_t    imm5;
   wisc_pkg::word_t    imm8;
   wisc_pkg::word_t    imm11;

   assign opcode = instr_d[15:11];
   assign src1   = instr_d[10:8];   // Rs
   assign src2   = instr_d[7:5];    // Rt, also the ST data register

   assign imm5  = {{(`WORD_W-5){instr_d[4]}}, instr_d[4:0]};
   assign imm8  = {{(`WORD_W-8){instr_d[7]}}, instr_d[7:0]};
   assign imm11 = {{(`WORD_W-11){instr_d[10]}}, instr_d[10:0]};

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         for (int i = 0; i < `REG_CNT; i++) begin
            regs[i] <= '0;
         end
      end else if (wr_en) begin
         regs[wr_sel] <= wr_data;
      end
   end

   // Writeback data bypasses the array, so a same-cycle read sees it
   assign rd1_data = (wr_en && wr_sel == src1) ? wr_data : regs[src1];
   assign rd2_data = (wr_en && wr_sel == src2) ? wr_data : regs[src2];

   always_comb begin
      reg_write = 1'b0;
      mem_read  = 1'b0;
      mem_write = 1'b0;
      alu_src   = 1'b0;
      link      = 1'b0;
      halt      = 1'b0;
      err       = 1'b0;
      dest      = instr_d[7:5];
      imm       = imm5;
      case (opcode)
         wisc_pkg::OP_HALT: halt = 1'b1;
         wisc_pkg::OP_NOP: begin
         end
         wisc_pkg::OP_ADDI, wisc_pkg::OP_SUBI, wisc_pkg::OP_XORI, wisc_pkg::OP_ANDNI: begin
            reg_write = 1'b1;
            alu_src   = 1'b1;
         end
         wisc_pkg::OP_RRR: begin
            reg_write = 1'b1;
            dest      = instr_d[4:2];
         end
         wisc_pkg::OP_LBI: begin
            reg_write = 1'b1;
            dest      = instr_d[10:8];
            imm       = imm8;
         end
         wisc_pkg::OP_ST: begin
            mem_write = 1'b1;
            alu_src   = 1'b1;       // Address is Rs + imm5
         end
         wisc_pkg::OP_LD: begin
            mem_read  = 1'b1;
            reg_write = 1'b1;
            alu_src   = 1'b1;
         end
         wisc_pkg::OP_BEQZ, wisc_pkg::OP_BNEZ: imm = imm8;
         wisc_pkg::OP_J: imm = imm11;
         wisc_pkg::OP_JAL: begin
            reg_write = 1'b1;
            link      = 1'b1;
            dest      = wisc_pkg::reg_sel_t'(`REG_CNT - 1);  // R7
            imm       = imm11;
         end
         default: err = 1'b1;       // Illegal, retires as a bubble
      endcase
   end

endmodule

`default_nettype wire

// ==== src/hazard_unit.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Hazard unit
// Read-after-write stall against execute and memory
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module hazard_unit (
   input  wisc_pkg::reg_sel_t src1,
   input  wisc_pkg::reg_sel_t src2,
   input  logic               uses_src2,
   input  wisc_pkg::reg_sel_t ex_dest,
   input  logic               ex_write,
   input  wisc_pkg::reg_sel_t mem_dest,
   input  logic               mem_write,
   output logic               stall
);

   logic hit_ex;
   logic hit_mem;

   // Producer in execute
   assign hit_ex = ex_write &&
                   (ex_dest == src1 || (uses_src2 && ex_dest == src2));

   // Producer in memory
   assign hit_mem = mem_write &&
                    (mem_dest == src1 || (uses_src2 && mem_dest == src2));

   // Writeback is covered by the register file bypass
   assign stall = hit_ex || hit_mem;

endmodule

`default_nettype wire

// ==== src/execute.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Execute stage
// ALU, branch test and redirect target
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module execute (
   input  wisc_pkg::opcode_t opcode,
   input  wisc_pkg::alu_op_t ext,
   input  wisc_pkg::word_t   rd1,
   input  wisc_pkg::word_t   rd2,
   input  wisc_pkg::word_t   imm,
   input  logic              alu_src,
   input  wisc_pkg::word_t   pc_next,
   output wisc_pkg::word_t   alu_out,
   output logic              redirect,
   output wisc_pkg::word_t   target
);

   wisc_pkg::alu_op_t alu_op;
   wisc_pkg::word_t   op_b;
   wisc_pkg::word_t   result;
   logic              zero;
   logic              taken;

   always_comb begin
      case (opcode)
         wisc_pkg::OP_SUBI:  alu_op = wisc_pkg::ALU_SUB;
         wisc_pkg::OP_XORI:  alu_op = wisc_pkg::ALU_XOR;
         wisc_pkg::OP_ANDNI: alu_op = wisc_pkg::ALU_ANDN;
         wisc_pkg::OP_RRR:   alu_op = ext;
         default:            alu_op = wisc_pkg::ALU_ADD;  // ADDI, ST, LD
      endcase
   end

   assign op_b = alu_src ? imm : rd2;

   always_comb begin
      case (alu_op)
         wisc_pkg::ALU_ADD: result = rd1 + op_b;
         wisc_pkg::ALU_SUB: result = op_b - rd1;
         wisc_pkg::ALU_XOR: result = rd1 ^ op_b;
         default:           result = rd1 & ~op_b;
      endcase
   end

   // Branch test on Rs
   assign zero  = (rd1 == '0);
   assign taken = (opcode == wisc_pkg::OP_BEQZ && zero) ||
                  (opcode == wisc_pkg::OP_BNEZ && !zero);

   assign target   = pc_next + imm;
   assign redirect = taken || opcode == wisc_pkg::OP_J || opcode == wisc_pkg::OP_JAL;

   // JAL stores the link, LBI the immediate
   assign alu_out = (opcode == wisc_pkg::OP_JAL) ? pc_next :
                    (opcode == wisc_pkg::OP_LBI) ? imm : result;

endmodule

`default_nettype wire

// ==== src/memory.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Data memory
// Word array, clocked write and async read
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none
`include "wisc_defines.svh"

module memory (
   input  logic            clk,
   input  wisc_pkg::word_t addr,
   input  wisc_pkg::word_t wdata,
   input  logic            write,
   output wisc_pkg::word_t rdata
);

   localparam int AW = $clog2(`DMEM_DEPTH);

   wisc_pkg::word_t mem [`DMEM_DEPTH];

   always_ff @(posedge clk) begin
      if (write) begin
         mem[addr[AW:1]] <= wdata;
      end
   end

   assign rdata = mem[addr[AW:1]];  // Byte address, word index

endmodule

`default_nettype wire

// ==== src/proc.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Five-stage WISC pipeline top
// Stage latches, hazard control and writeback
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module proc (
   input  logic               clk,
   input  logic               arst_n,
   input  logic               load_en,
   input  wisc_pkg::word_t    load_addr,
   input  wisc_pkg::word_t    load_data,
   input  logic               start,
   output logic               wb_valid,
   output wisc_pkg::reg_sel_t wb_sel,
   output wisc_pkg::word_t    wb_data,
   output logic               halted,
   output logic               err
);

   wisc_pkg::word_t    instr_f, pc_next_f;
   wisc_pkg::word_t    instr_d, pc_next_d, rd1_d, rd2_d, imm_d;
   wisc_pkg::reg_sel_t dest_d;
   logic               reg_write_d, mem_read_d, mem_write_d, alu_src_d, link_d, halt_d;
   logic               uses_src2, stall_raw, stall, drain, bubble_e;
   wisc_pkg::opcode_t  opcode_e;
   wisc_pkg::alu_op_t  ext_e;
   wisc_pkg::word_t    rd1_e, rd2_e, imm_e, pc_next_e, alu_out_e, target;
   wisc_pkg::reg_sel_t dest_e;
   logic               reg_write_e, mem_read_e, mem_write_e, alu_src_e, halt_e, redirect;
   wisc_pkg::word_t    alu_m, rd2_m, read_data;
   wisc_pkg::reg_sel_t dest_m;
   logic               reg_write_m, mem_read_m, mem_write_m, halt_m;
   wisc_pkg::word_t    alu_w, rdata_w;
   wisc_pkg::reg_sel_t dest_w;
   logic               reg_write_w, mem_read_w, halt_w;

   fetch u_fetch (
      .clk(clk), .arst_n(arst_n),
      .load_en(load_en), .load_addr(load_addr), .load_data(load_data),
      .start(start), .stall(stall), .redirect(redirect), .target(target),
      .halt_wb(halt_w),
      .instr_f(instr_f), .pc_next_f(pc_next_f), .halted(halted)
   );

   // HALT anywhere past fetch keeps younger instructions out
   assign drain = halt_d || halt_e || halt_m || halt_w;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         instr_d <= wisc_pkg::NOP_INSTR;
      end else if (redirect) begin
         instr_d <= wisc_pkg::NOP_INSTR;
      end else if (!stall) begin
         instr_d <= drain ? wisc_pkg::NOP_INSTR : instr_f;
      end
   end

   always_ff @(posedge clk) begin
      if (!stall) begin
         pc_next_d <= pc_next_f;
      end
   end

   decode u_decode (
      .clk(clk), .arst_n(arst_n), .instr_d(instr_d),
      .wr_en(reg_write_w), .wr_sel(dest_w), .wr_data(wb_data),
      .rd1_data(rd1_d), .rd2_data(rd2_d), .imm(imm_d), .dest(dest_d),
      .reg_write(reg_write_d), .mem_read(mem_read_d), .mem_write(mem_write_d),
      .alu_src(alu_src_d), .link(link_d), .halt(halt_d), .err(err)
   );

   assign uses_src2 = (instr_d[15:11] == wisc_pkg::OP_RRR) || mem_write_d;

   hazard_unit u_hazard (
      .src1(instr_d[10:8]), .src2(instr_d[7:5]), .uses_src2(uses_src2),
      .ex_dest(dest_e), .ex_write(reg_write_e),
      .mem_dest(dest_m), .mem_write(reg_write_m),
      .stall(stall_raw)
   );

   assign stall    = stall_raw && !link_d;  // JAL reads no register
   assign bubble_e = stall || redirect;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         opcode_e    <= wisc_pkg::OP_NOP;
         reg_write_e <= 1'b0;
         mem_read_e  <= 1'b0;
         mem_write_e <= 1'b0;
         halt_e      <= 1'b0;
      end else begin
         opcode_e    <= bubble_e ? wisc_pkg::OP_NOP : instr_d[15:11];
         reg_write_e <= reg_write_d && !bubble_e;
         mem_read_e  <= mem_read_d && !bubble_e;
         mem_write_e <= mem_write_d && !bubble_e;
         halt_e      <= halt_d && !bubble_e;
      end
   end

   always_ff @(posedge clk) begin
      ext_e     <= instr_d[1:0];
      rd1_e     <= rd1_d;
      rd2_e     <= rd2_d;
      imm_e     <= imm_d;
      dest_e    <= dest_d;
      alu_src_e <= alu_src_d;
      pc_next_e <= pc_next_d;
   end

   execute u_execute (
      .opcode(opcode_e), .ext(ext_e), .rd1(rd1_e), .rd2(rd2_e), .imm(imm_e),
      .alu_src(alu_src_e), .pc_next(pc_next_e),
      .alu_out(alu_out_e), .redirect(redirect), .target(target)
   );

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         reg_write_m <= 1'b0;
         mem_read_m  <= 1'b0;
         mem_write_m <= 1'b0;
         halt_m      <= 1'b0;
         reg_write_w <= 1'b0;
         halt_w      <= 1'b0;
      end else begin
         reg_write_m <= reg_write_e;
         mem_read_m  <= mem_read_e;
         mem_write_m <= mem_write_e;
         halt_m      <= halt_e;
         reg_write_w <= reg_write_m;
         halt_w      <= halt_m;
      end
   end

   always_ff @(posedge clk) begin
      alu_m      <= alu_out_e;
      rd2_m      <= rd2_e;        // Store data
      dest_m     <= dest_e;
      alu_w      <= alu_m;
      rdata_w    <= read_data;
      dest_w     <= dest_m;
      mem_read_w <= mem_read_m;
   end

   memory u_memory (
      .clk(clk), .addr(alu_m), .wdata(rd2_m), .write(mem_write_m), .rdata(read_data)
   );

   // Writeback mux
   assign wb_data  = mem_read_w ? rdata_w : alu_w;
   assign wb_valid = reg_write_w;
   assign wb_sel   = dest_w;

endmodule

`default_nettype wire

// ==== bench/isa_model.svh ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// WISC instruction-set reference model
// Runs the program one instruction at a time
// and records the expected register writes in order
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef ISA_MODEL_SVH
`define ISA_MODEL_SVH

wisc_pkg::reg_sel_t exp_sel  [`IMEM_DEPTH * 4];
wisc_pkg::word_t    exp_data [`IMEM_DEPTH * 4];

// Returns the number of expected writes, reads prog
function automatic int run_model();
   wisc_pkg::word_t    regs [`REG_CNT];
   wisc_pkg::word_t    dmem [`DMEM_DEPTH];
   wisc_pkg::word_t    pc;
   wisc_pkg::word_t    ins;
   wisc_pkg::word_t    a;
   wisc_pkg::word_t    b;
   wisc_pkg::word_t    i5;
   wisc_pkg::word_t    i8;
   wisc_pkg::word_t    i11;
   wisc_pkg::word_t    res;
   wisc_pkg::word_t    addr;
   wisc_pkg::reg_sel_t rd;
   logic               wr;
   int                 cnt;
   int                 r;
   int                 step;
   cnt = 0;
   pc  = `PC_RESET;
   for (r = 0; r < `REG_CNT; r++) begin
      regs[r] = '0;   // Register file resets to zero
   end
   for (step = 0; step < 2000; step++) begin
      ins = prog[pc[8:1]];
      a   = regs[ins[10:8]];              // Rs
      b   = regs[ins[7:5]];               // Rt
      i5  = {{11{ins[4]}}, ins[4:0]};
      i8  = {{8{ins[7]}}, ins[7:0]};
      i11 = {{5{ins[10]}}, ins[10:0]};
      wr  = 1'b1;
      rd  = ins[7:5];
      res = '0;
      pc  = pc + 16'd2;
      case (ins[15:11])
         wisc_pkg::OP_HALT:  return cnt;
         wisc_pkg::OP_ADDI:  res = a + i5;
         wisc_pkg::OP_SUBI:  res = i5 - a;
         wisc_pkg::OP_XORI:  res = a ^ i5;
         wisc_pkg::OP_ANDNI: res = a & ~i5;
         wisc_pkg::OP_RRR: begin
            rd = ins[4:2];
            case (ins[1:0])
               2'b00:   res = a + b;
               2'b01:   res = b - a;
               2'b10:   res = a ^ b;
               default: res = a & ~b;
            endcase
         end
         wisc_pkg::OP_LBI: begin
            rd  = ins[10:8];
            res = i8;
         end
         wisc_pkg::OP_ST: begin
            addr = a + i5;
            dmem[addr[8:1]] = b;
            wr = 1'b0;
         end
         wisc_pkg::OP_LD: begin
            addr = a + i5;
            res  = dmem[addr[8:1]];
         end
         wisc_pkg::OP_BEQZ: begin
            wr = 1'b0;
            if (a == '0) pc = pc + i8;
         end
         wisc_pkg::OP_BNEZ: begin
            wr = 1'b0;
            if (a != '0) pc = pc + i8;
         end
         wisc_pkg::OP_J: begin
            wr = 1'b0;
            pc = pc + i11;
         end
         wisc_pkg::OP_JAL: begin
            rd  = 3'd7;   // Link register
            res = pc;
            pc  = pc + i11;
         end
         default: wr = 1'b0;   // NOP and illegal opcodes
      endcase
      if (wr) begin
         regs[rd]      = res;
         exp_sel[cnt]  = rd;
         exp_data[cnt] = res;
         cnt++;
      end
   end
   return cnt;
endfunction

`endif

// ==== bench/proc_tb.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the WISC pipeline
// Random programs checked against an ISA model
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`include "wisc_defines.svh"

module proc_tb;

   logic               clk;
   logic               arst_n;
   logic               load_en;
   wisc_pkg::word_t    load_addr;
   wisc_pkg::word_t    load_data;
   logic               start;
   logic               wb_valid;
   wisc_pkg::reg_sel_t wb_sel;
   wisc_pkg::word_t    wb_data;
   logic               halted;
   logic               err;

   wisc_pkg::word_t prog [`IMEM_DEPTH];
   integer          seed;
   int              prog_len;
   int              exp_cnt;
   int              exp_idx;
   int              errors;
   int              checks;
   logic            err_seen;
   string           test_name;

   `include "isa_model.svh"

   proc dut (
      .clk(clk), .arst_n(arst_n),
      .load_en(load_en), .load_addr(load_addr), .load_data(load_data),
      .start(start),
      .wb_valid(wb_valid), .wb_sel(wb_sel), .wb_data(wb_data),
      .halted(halted), .err(err)
   );

   always #50 clk = ~clk;   // 100 ns period

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("FAILED %s expected %0h actual %0h", name, expected, actual);
      end
   endtask

   // One expected entry per retiring write, sampled mid-cycle
   always @(negedge clk) begin
      if (arst_n && wb_valid) begin
         if (exp_idx < exp_cnt) begin
            check_value($sformatf("%s wb %0d sel", test_name, exp_idx),
                        exp_sel[exp_idx], wb_sel);
            check_value($sformatf("%s wb %0d data", test_name, exp_idx),
                        exp_data[exp_idx], wb_data);
         end else begin
            errors++;
            $display("%s: unexpected writeback to R%0d", test_name, wb_sel);
         end
         exp_idx++;
      end
   end

   function automatic void emit(input wisc_pkg::word_t w);
      prog[prog_len] = w;
      prog_len++;
   endfunction

   function automatic wisc_pkg::word_t imm_form(input wisc_pkg::opcode_t op,
         input wisc_pkg::reg_sel_t rs, input wisc_pkg::reg_sel_t rt, input logic [4:0] imm5);
      return {op, rs, rt, imm5};
   endfunction

   function automatic wisc_pkg::word_t byte_form(input wisc_pkg::opcode_t op,
         input wisc_pkg::reg_sel_t rs, input logic [7:0] imm8);
      return {op, rs, imm8};
   endfunction

   function automatic wisc_pkg::word_t jump_form(input wisc_pkg::opcode_t op,
                                                 input logic [10:0] imm11);
      return {op, imm11};
   endfunction

   // Immediate or register-register op on random registers
   function automatic wisc_pkg::word_t random_alu();
      logic [31:0]       r;
      wisc_pkg::opcode_t op;
      r = $random(seed);
      case (r[13:11])
         3'd0:    op = wisc_pkg::OP_ADDI;
         3'd1:    op = wisc_pkg::OP_SUBI;
         3'd2:    op = wisc_pkg::OP_XORI;
         3'd3:    op = wisc_pkg::OP_ANDNI;
         default: op = wisc_pkg::OP_RRR;
      endcase
      return {op, r[10:0]};
   endfunction

   // Control transfer followed by two slot writes to R5 and R6
   task automatic emit_with_slots(input wisc_pkg::word_t w);
      logic [31:0] r;
      r = $random(seed);
      emit(w);
      emit(imm_form(wisc_pkg::OP_ADDI, 3'd5, 3'd5, r[4:0]));
      emit(imm_form(wisc_pkg::OP_XORI, 3'd6, 3'd6, r[9:5]));
   endtask

   task automatic build_program();
      logic [31:0] r;
      logic [7:0]  addrs [4];
      logic [4:0]  offs [4];
      int          k;
      prog_len = 0;
      for (k = 0; k < 8; k++) begin
         r = $random(seed);
         emit(byte_form(wisc_pkg::OP_LBI, wisc_pkg::reg_sel_t'(k), r[7:0]));
      end
      for (k = 0; k < 12; k++) begin
         emit(random_alu());   // Back-to-back dependences
      end
      for (k = 0; k < 4; k++) begin
         r = $random(seed);
         addrs[k] = r[7:0];
         offs[k]  = r[12:8];
         emit(byte_form(wisc_pkg::OP_LBI, 3'd1, addrs[k]));
         emit(imm_form(wisc_pkg::OP_ST, 3'd1, wisc_pkg::reg_sel_t'(k + 2), offs[k]));
      end
      for (k = 0; k < 4; k++) begin
         emit(byte_form(wisc_pkg::OP_LBI, 3'd1, addrs[k]));
         emit(imm_form(wisc_pkg::OP_LD, 3'd1, wisc_pkg::reg_sel_t'(2 + (k + 1) % 4), offs[k]));
      end
      emit(byte_form(wisc_pkg::OP_LBI, 3'd3, 8'd0));
      emit(byte_form(wisc_pkg::OP_LBI, 3'd4, 8'd5));
      emit_with_slots(byte_form(wisc_pkg::OP_BEQZ, 3'd3, 8'd4));   // Taken
      emit_with_slots(byte_form(wisc_pkg::OP_BNEZ, 3'd3, 8'd4));   // Falls through
      emit_with_slots(byte_form(wisc_pkg::OP_BNEZ, 3'd4, 8'd4));   // Taken
      emit_with_slots(byte_form(wisc_pkg::OP_BEQZ, 3'd4, 8'd4));   // Falls through
      emit_with_slots(jump_form(wisc_pkg::OP_J, 11'd4));
      emit_with_slots(jump_form(wisc_pkg::OP_JAL, 11'd4));
      emit(imm_form(wisc_pkg::OP_ADDI, 3'd7, 3'd2, 5'd0));        // Copy of the link
      emit(random_alu());
      r = $random(seed);
      emit({5'b11111, r[10:0]});                                   // Illegal opcode
      for (k = 0; k < 4; k++) begin
         emit(random_alu());
      end
      emit(jump_form(wisc_pkg::OP_HALT, 11'd0));
   endtask

   task automatic reset_dut();
      @(posedge clk);
      #1 arst_n = 1'b0;
      repeat (2) @(posedge clk);
      #1 arst_n = 1'b1;
   endtask

   task automatic load_program();
      int i;
      for (i = 0; i < prog_len; i++) begin
         @(posedge clk);
         #1;
         load_en   = 1'b1;
         load_addr = wisc_pkg::word_t'(i * 2);
         load_data = prog[i];
      end
      @(posedge clk);
      #1 load_en = 1'b0;
      start = 1'b1;
      @(posedge clk);
      #1 start = 1'b0;
   endtask

   task automatic run_program(input string name);
      int cyc;
      build_program();
      exp_cnt   = run_model();
      exp_idx   = 0;
      err_seen  = 1'b0;
      test_name = name;
      reset_dut();
      load_program();
      for (cyc = 0; cyc < 3000 && !halted; cyc++) begin
         @(negedge clk);
         if (err) err_seen = 1'b1;
      end
      if (!halted) begin
         errors++;
         $display("%s: halted did not rise within 3000 cycles", name);
      end
      if (!err_seen) begin
         errors++;
         $display("%s: err never rose for the illegal opcode", name);
      end
      repeat (20) @(negedge clk);   // Quiet window after halt
      check_value({name, " writeback count"}, exp_cnt, exp_idx);
      check_value({name, " halted held"}, 1, halted);
   endtask

   initial begin
      clk       = 1'b0;
      arst_n    = 1'b0;
      load_en   = 1'b0;
      load_addr = '0;
      load_data = '0;
      start     = 1'b0;
      seed      = 32'h7e66e860;
      errors    = 0;
      checks    = 0;
      exp_cnt   = 0;
      exp_idx   = 0;
      test_name = "idle";
      run_program("program_a");
      run_program("program_b");      // Second program after a fresh reset
      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

endmodule

// ==== list.f ====
+incdir+src
+incdir+bench
src/wisc_pkg.sv
src/fetch.sv
src/decode.sv
src/hazard_unit.sv
src/execute.sv
src/memory.sv
src/proc.sv
bench/proc_tb.sv

// ==== Bender.yml ====
package:
  name: wisc_proc

sources:
  - include_dirs:
      - src
    files:
      - src/wisc_pkg.sv
      - src/fetch.sv
      - src/decode.sv
      - src/hazard_unit.sv
      - src/execute.sv
      - src/memory.sv
      - src/proc.sv
  - target: test
    include_dirs:
      - src
      - bench
    files:
      - bench/proc_tb.sv
